/* Bender.yml */
package:
  name: mvu_ctrl

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mvu_ctrl_pkg.sv
      - logic/mvu_job_regs.sv
      - logic/mvu_countdown.sv
      - logic/mvu_bitser_agu.sv
      - logic/mvu_acc_sequencer.sv
      - logic/mvu_ctrl_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/mvu_ctrl_chk.sv
      - testbench/mvu_ctrl_tb.sv

/* logic/mvu_acc_sequencer.sv */
// ########################################
// Accumulator and output write sequencer
// Controls trail addresses by PIPE_DELAY cycles
// Writes trail loads by SCALER_LATENCY cycles
// ########################################

`include "mvu_ctrl_settings.svh"

module mvu_acc_sequencer (
    input  logic                    mvu_ext,
    input  logic                    rst_n,
    input  logic                    clr,
    input  logic                    run,
    input  logic                    w_msb,
    input  logic                    d_msb,
    input  logic                    word_end,
    input  mvu_ctrl_pkg::job_cfg_t  job,
    output mvu_ctrl_pkg::acc_ctrl_t acc,
    output mvu_ctrl_pkg::out_req_t  out
);

    import mvu_ctrl_pkg::*;

    localparam int PD = `MVU_PIPE_DELAY;
    localparam int SL = `MVU_SCALER_LATENCY;
    localparam int CD = PD + SL;                // Clear travels with the first word of a job

    acc_ctrl_t             ctrl_now;
    acc_ctrl_t             ctrl_q [PD];
    logic [SL-1:0]         ld_q;
    logic [CD-1:0]         clr_q;
    logic [`MVU_BADDR-1:0] ocnt;
    logic [`MVU_BADDR-1:0] oaddr;

    // Controls for the bits addressed in this cycle
    always_comb begin
        ctrl_now.neg  = run & ((job.d_signed & d_msb) ^ (job.w_signed & w_msb));
        ctrl_now.sh   = run & ~(w_msb & d_msb);   // Both at bit 0 opens a new word
        ctrl_now.acc  = run;
        ctrl_now.load = word_end;                 // Already qualified by run
    end

    // Datapath alignment
    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PD; i++) begin
                ctrl_q[i] <= '0;
            end
        end else begin
            ctrl_q[0] <= ctrl_now;
            for (int i = 1; i < PD; i++) begin
                ctrl_q[i] <= ctrl_q[i-1];
            end
        end
    end

    assign acc = ctrl_q[PD-1];

    // Scaler latency and delayed job clear
    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            ld_q  <= '0;
            clr_q <= '0;
        end else begin
            ld_q[0]  <= acc.load;
            clr_q[0] <= clr;
            for (int i = 1; i < SL; i++) begin
                ld_q[i] <= ld_q[i-1];
            end
            for (int i = 1; i < CD; i++) begin
                clr_q[i] <= clr_q[i-1];
            end
        end
    end

    // The base reloads only when the new job's first write could
    // arrive, so strobes of a replaced job drain at their own addresses
    assign oaddr = clr_q[CD-1] ? job.obaseaddr : ocnt;

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            ocnt <= '0;
        end else begin
            ocnt <= oaddr + {{(`MVU_BADDR-1){1'b0}}, ld_q[SL-1]};
        end
    end

    assign out = '{addr: oaddr, strobe: ld_q[SL-1]};

endmodule

/* logic/mvu_bitser_agu.sv */
// ########################################
// Bit-serial address generator
// Walks linear words of precision bits, MSB first
// clr zeroes the walk within the same cycle
// ########################################

`include "mvu_ctrl_settings.svh"

module mvu_bitser_agu (
    input  logic                  mvu_ext,
    input  logic                  rst_n,
    input  logic                  clr,
    input  logic                  step,
    input  logic [`MVU_BPREC-1:0] precision,
    input  logic [`MVU_BADDR-1:0] baseaddr,
    output logic [`MVU_BADDR-1:0] addr,
    output logic                  msb,
    output logic                  wrap
);

    localparam int PAD = `MVU_BADDR - `MVU_BPREC;

    logic [`MVU_BPREC-1:0] bidx_q;      // Bit position within the word, 0 is MSB
    logic [`MVU_BPREC-1:0] bidx_cur;
    logic [`MVU_BADDR-1:0] off_q;       // Start of the current word
    logic [`MVU_BADDR-1:0] off_cur;
    logic [`MVU_BADDR-1:0] bidx_ext;
    logic [`MVU_BADDR-1:0] prec_ext;
    logic                  last;

    // A clear takes effect in its own cycle so the first
    // address of a job is already the base address
    assign bidx_cur = clr ? '0 : bidx_q;
    assign off_cur  = clr ? '0 : off_q;

    assign bidx_ext = {{PAD{1'b0}}, bidx_cur};
    assign prec_ext = {{PAD{1'b0}}, precision};
    assign last     = (bidx_cur == precision - 1'b1);

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            bidx_q <= '0;
            off_q  <= '0;
        end else if (step) begin
            if (last) begin
                bidx_q <= '0;
                off_q  <= off_cur + prec_ext;   // Next word
            end else begin
                bidx_q <= bidx_cur + 1'b1;
                off_q  <= off_cur;
            end
        end else begin
            bidx_q <= bidx_cur;
            off_q  <= off_cur;
        end
    end

    assign addr = baseaddr + off_cur + bidx_ext;
    assign msb  = (bidx_cur == '0);
    assign wrap = step & last;                  // Only flags a bit that is actually consumed

endmodule

/* logic/mvu_countdown.sv */
// ########################################
// Job run controller
// countdown of 0 behaves like 1
// A new start_q restarts a running job
// ########################################

`include "mvu_ctrl_settings.svh"

module mvu_countdown (
    input  logic                    mvu_ext,
    input  logic                    rst_n,
    input  logic                    start_q,
    input  logic [`MVU_BCNTDWN-1:0] countdown,
    output logic                    run,
    output logic                    done,
    output logic                    irq
);

    import mvu_ctrl_pkg::*;

    ctrl_state_e             state, state_d;
    logic [`MVU_BCNTDWN-1:0] cnt, cnt_d;       // Run cycles left after the current one
    logic                    irq_q;

    always_comb begin
        state_d = state;
        cnt_d   = cnt;
        case (state)
            CTRL_RUN: begin
                if (cnt == '0) begin
                    state_d = CTRL_DONE;       // Last run cycle
                end else begin
                    cnt_d = cnt - 1'b1;
                end
            end
            CTRL_DONE: state_d = CTRL_IDLE;
            default: state_d = state;
        endcase
        if (start_q) begin                     // First run cycle is the start_q cycle itself
            cnt_d   = countdown - 2'd2;
            state_d = (countdown > 1) ? CTRL_RUN : CTRL_DONE;
        end
    end

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_IDLE;
            cnt   <= '0;
            irq_q <= 1'b0;
        end else begin
            state <= state_d;
            cnt   <= cnt_d;
            irq_q <= (state_d == CTRL_DONE) | (irq_q & ~start_q);
        end
    end

    assign run  = start_q | (state == CTRL_RUN);
    assign done = (state == CTRL_DONE);
    assign irq  = irq_q & ~start_q;            // Drops as soon as the next job is taken

endmodule

/* logic/mvu_ctrl_pkg.sv */
// ########################################
// Shared types of the MVU control slice
// Widths come from the settings header
// ########################################

`include "mvu_ctrl_settings.svh"

package mvu_ctrl_pkg;

    // Job configuration, latched on start
    typedef struct packed {
        logic [`MVU_BCNTDWN-1:0] countdown;   // Number of run cycles
        logic [`MVU_BPREC-1:0]   wprecision;  // Weight bits per word
        logic [`MVU_BPREC-1:0]   iprecision;  // Input data bits per word
        logic [`MVU_BADDR-1:0]   wbaseaddr;   // First weight word
        logic [`MVU_BADDR-1:0]   ibaseaddr;   // First input data word
        logic [`MVU_BADDR-1:0]   obaseaddr;   // First output word
        logic                    w_signed;    // Weights are two's complement
        logic                    d_signed;    // Data is two's complement
    } job_cfg_t;

    // Memory read request
    typedef struct packed {
        logic [`MVU_BADDR-1:0] addr;
        logic                  valid;
    } mem_req_t;

    // Shift-accumulator controls
    typedef struct packed {
        logic neg;   // Negate partial product on a sign bit
        logic sh;    // Shift before accumulating
        logic acc;   // Accumulate enable
        logic load;  // Hand the finished word to the scaler
    } acc_ctrl_t;

    // Output memory write
    typedef struct packed {
        logic [`MVU_BADDR-1:0] addr;
        logic                  strobe;
    } out_req_t;

    // Job controller states
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_RUN,
        CTRL_DONE
    } ctrl_state_e;

endpackage

/* logic/mvu_ctrl_settings.svh */
// ########################################
// Widths and latencies of the MVU control slice
// Precision values must lie between 1 and 8
// PIPE_DELAY and SCALER_LATENCY must be at least 1
// ########################################

`ifndef MVU_CTRL_SETTINGS_SVH
`define MVU_CTRL_SETTINGS_SVH

// Width of a precision field
`define MVU_BPREC 4

// Width of weight, data and output memory addresses
`define MVU_BADDR 10

// Width of the job countdown field
`define MVU_BCNTDWN 12

// Memory read latency plus multiplier stages,
// counted from read address to accumulator control
`define MVU_PIPE_DELAY 3

// Cycles from accumulator load to output write
`define MVU_SCALER_LATENCY 2

`endif

/* logic/mvu_ctrl_top.sv */
// ########################################
// MVU control slice, single unit
// start is a one-cycle strobe, no back-pressure
// ########################################

`include "mvu_ctrl_settings.svh"

module mvu_ctrl_top (
    input  logic                    mvu_ext,
    input  logic                    rst_n,
    input  logic                    start,
    input  mvu_ctrl_pkg::job_cfg_t  cfg,
    output mvu_ctrl_pkg::mem_req_t  wreq,
    output mvu_ctrl_pkg::mem_req_t  dreq,
    output mvu_ctrl_pkg::acc_ctrl_t acc,
    output mvu_ctrl_pkg::out_req_t  out,
    output logic                    done,
    output logic                    irq
);

    import mvu_ctrl_pkg::*;

    job_cfg_t              job;
    logic                  start_q;
    logic                  run;
    logic [`MVU_BADDR-1:0] w_addr;
    logic [`MVU_BADDR-1:0] d_addr;
    logic                  w_msb;
    logic                  d_msb;
    logic                  w_wrap;     // Last weight bit, steps the data walk
    logic                  d_wrap;     // Last bit of a whole word

    mvu_job_regs u_job_regs (
        .mvu_ext (mvu_ext),
        .rst_n   (rst_n),
        .start   (start),
        .cfg     (cfg),
        .job     (job),
        .start_q (start_q)
    );

    mvu_countdown u_countdown (
        .mvu_ext   (mvu_ext),
        .rst_n     (rst_n),
        .start_q   (start_q),
        .countdown (job.countdown),
        .run       (run),
        .done      (done),
        .irq       (irq)
    );

    // Weight bits form the inner loop
    mvu_bitser_agu u_wagu (
        .mvu_ext   (mvu_ext),
        .rst_n     (rst_n),
        .clr       (start_q),
        .step      (run),
        .precision (job.wprecision),
        .baseaddr  (job.wbaseaddr),
        .addr      (w_addr),
        .msb       (w_msb),
        .wrap      (w_wrap)
    );

    mvu_bitser_agu u_dagu (
        .mvu_ext   (mvu_ext),
        .rst_n     (rst_n),
        .clr       (start_q),
        .step      (w_wrap),
        .precision (job.iprecision),
        .baseaddr  (job.ibaseaddr),
        .addr      (d_addr),
        .msb       (d_msb),
        .wrap      (d_wrap)
    );

    mvu_acc_sequencer u_acc_seq (
        .mvu_ext  (mvu_ext),
        .rst_n    (rst_n),
        .clr      (start_q),
        .run      (run),
        .w_msb    (w_msb),
        .d_msb    (d_msb),
        .word_end (d_wrap),
        .job      (job),
        .acc      (acc),
        .out      (out)
    );

    assign wreq = '{addr: w_addr, valid: run};
    assign dreq = '{addr: d_addr, valid: run};

endmodule

/* logic/mvu_job_regs.sv */
// ########################################
// Job configuration latch
// cfg must be valid in the cycle start is high
// Reset job has precision 1 and zero addresses
// ########################################

`include "mvu_ctrl_settings.svh"

module mvu_job_regs (
    input  logic                   mvu_ext,
    input  logic                   rst_n,
    input  logic                   start,
    input  mvu_ctrl_pkg::job_cfg_t cfg,
    output mvu_ctrl_pkg::job_cfg_t job,
    output logic                   start_q
);

    import mvu_ctrl_pkg::*;

    // Harmless job seen before the first start
    localparam job_cfg_t JOB_RESET = '{
        countdown:  '0,
        wprecision: `MVU_BPREC'(1),
        iprecision: `MVU_BPREC'(1),
        wbaseaddr:  '0,
        ibaseaddr:  '0,
        obaseaddr:  '0,
        w_signed:   1'b0,
        d_signed:   1'b0
    };

    // The start pulse trails the strobe by one cycle so that
    // everything downstream sees the new job already in place
    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start;
        end
    end

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            job <= JOB_RESET;
        end else if (start) begin
            job <= cfg;                   // Hold until next start
        end
    end

endmodule

/* mvu_ctrl_top.f */
+incdir+logic
logic/mvu_ctrl_pkg.sv
logic/mvu_job_regs.sv
logic/mvu_countdown.sv
logic/mvu_bitser_agu.sv
logic/mvu_acc_sequencer.sv
logic/mvu_ctrl_top.sv
testbench/mvu_ctrl_chk.sv
testbench/mvu_ctrl_tb.sv

/* testbench/mvu_ctrl_chk.sv */
// ########################################
// Control checks, bound into the controller
// and the accumulator sequencer
// Ports unused by a target are tied off
// ########################################

`include "mvu_ctrl_settings.svh"

module mvu_ctrl_chk (
    input logic                    mvu_ext,
    input logic                    rst_n,
    input logic                    run,
    input logic                    done,
    input mvu_ctrl_pkg::ctrl_state_e state,
    input mvu_ctrl_pkg::acc_ctrl_t acc,
    input mvu_ctrl_pkg::out_req_t  out
);

    import mvu_ctrl_pkg::*;

    int unsigned fails = 0;                    // Failed assertion count

    // The controller leaves CTRL_DONE right after the pulse
    a_done_pulse: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        done |=> (state != CTRL_DONE))
        else begin $error("done is not a one-cycle pulse"); fails++; end

    a_run_done: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        !(run && done))
        else begin $error("run and done high together"); fails++; end

    a_load_acc: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        acc.load |-> acc.acc)
        else begin $error("acc.load without acc.acc"); fails++; end

    // Every write needs its load one scaler latency earlier
    a_strobe_load: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        out.strobe |-> $past(acc.load, `MVU_SCALER_LATENCY))
        else begin $error("out.strobe without an earlier acc.load"); fails++; end

endmodule

bind mvu_countdown mvu_ctrl_chk u_chk (
    .mvu_ext (mvu_ext),
    .rst_n   (rst_n),
    .run     (run),
    .done    (done),
    .state   (state),
    .acc     ('0),
    .out     ('0)
);

bind mvu_acc_sequencer mvu_ctrl_chk u_chk (
    .mvu_ext (mvu_ext),
    .rst_n   (rst_n),
    .run     (run),
    .done    (1'b0),
    .state   (mvu_ctrl_pkg::CTRL_IDLE),
    .acc     (acc),
    .out     (out)
);

/* testbench/mvu_ctrl_tb.sv */
// ########################################
// Testbench for the MVU control slice
// Jobs start on done, gap counts extra idle cycles
// Outputs are sampled on the falling clock edge
// ########################################

`include "mvu_ctrl_settings.svh"

module mvu_ctrl_tb;

    import mvu_ctrl_pkg::*;

    localparam int PD    = `MVU_PIPE_DELAY;
    localparam int SL    = `MVU_SCALER_LATENCY;
    localparam int N     = 512;            // Longest run in cycles
    localparam int IDLE  = 3;              // Quiet cycles after reset
    localparam int NJOBS = 8;
    localparam logic [31:0] SEED = 32'hf5840f38;

    typedef struct packed {
        int   wp;
        int   ip;
        int   words;
        logic ws;
        logic ds;
        int   gap;
    } job_row_t;

    // Precisions, words, signs and idle gap before the next start
    localparam job_row_t JOBS [NJOBS] = '{
        '{2, 3, 2, 1'b0, 1'b0, 4},
        '{1, 2, 3, 1'b1, 1'b0, 0},
        '{3, 1, 2, 1'b0, 1'b1, 0},
        '{4, 2, 2, 1'b1, 1'b1, 3},
        '{1, 1, 5, 1'b1, 1'b1, 0},         // A load on every cycle
        '{8, 3, 1, 1'b1, 1'b0, 0},
        '{2, 5, 3, 1'b0, 1'b1, 2},
        '{1, 1, 1, 1'b0, 1'b0, 8}          // Single run cycle, then drain
    };

    logic      mvu_ext;
    logic      rst_n;
    logic      start;
    job_cfg_t  cfg;
    mem_req_t  wreq;
    mem_req_t  dreq;
    acc_ctrl_t acc;
    out_req_t  out;
    logic      done;
    logic      irq;

    logic [`MVU_BADDR-1:0] wbase [NJOBS];
    logic [`MVU_BADDR-1:0] ibase [NJOBS];
    logic [`MVU_BADDR-1:0] obase [NJOBS];
    mem_req_t              exp_wreq [N];
    mem_req_t              exp_dreq [N];
    acc_ctrl_t             exp_acc [N];
    out_req_t              exp_out [N];
    logic                  exp_done [N];
    logic                  exp_irq [N];
    int                    cyc;
    int unsigned           limit;

    mvu_ctrl_top uut (
        .mvu_ext (mvu_ext),
        .rst_n   (rst_n),
        .start   (start),
        .cfg     (cfg),
        .wreq    (wreq),
        .dreq    (dreq),
        .acc     (acc),
        .out     (out),
        .done    (done),
        .irq     (irq)
    );

    initial begin
        mvu_ext = 1'b0;
        forever #2 mvu_ext = ~mvu_ext;
    end

    task automatic check_req(input string what, input mem_req_t got, input mem_req_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.addr !== exp.addr)) begin
            $display("[FAIL] %0t: %s got addr %0d valid %0b, expected addr %0d valid %0b",
                     $time, what, got.addr, got.valid, exp.addr, exp.valid);
            $display("test failed");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_acc(input acc_ctrl_t got, input acc_ctrl_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: acc got neg/sh/acc/load %b, expected %b", $time, got, exp);
            $display("test failed");
            $fatal(1, "acc mismatch");
        end
    endtask

    task automatic check_out(input out_req_t got, input out_req_t exp);
        if (got.strobe !== exp.strobe || (exp.strobe && got.addr !== exp.addr)) begin
            $display("[FAIL] %0t: out got addr %0d strobe %0b, expected addr %0d strobe %0b",
                     $time, got.addr, got.strobe, exp.addr, exp.strobe);
            $display("test failed");
            $fatal(1, "out mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %b, expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    function automatic job_cfg_t job_cfg(input int j);
        job_cfg_t c;
        c.countdown  = `MVU_BCNTDWN'(JOBS[j].wp * JOBS[j].ip * JOBS[j].words);
        c.wprecision = `MVU_BPREC'(JOBS[j].wp);
        c.iprecision = `MVU_BPREC'(JOBS[j].ip);
        c.wbaseaddr  = wbase[j];
        c.ibaseaddr  = ibase[j];
        c.obaseaddr  = obase[j];
        c.w_signed   = JOBS[j].ws;
        c.d_signed   = JOBS[j].ds;
        return c;
    endfunction

    function automatic job_cfg_t junk_cfg();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[$bits(job_cfg_t)-1:0];
    endfunction

    // Expected outputs per cycle, from the walk and delay rules
    task automatic build_model();
        int        s, nxt, cd, wp, ip, wl, t, c, wbit, dbit, word;
        logic [31:0] r;
        acc_ctrl_t a;
        for (int i = 0; i < N; i++) begin
            exp_wreq[i] = '0;
            exp_dreq[i] = '0;
            exp_acc[i]  = '0;
            exp_out[i]  = '0;
            exp_done[i] = 1'b0;
            exp_irq[i]  = 1'b0;
        end
        s     = IDLE;
        limit = IDLE;
        for (int j = 0; j < NJOBS; j++) begin
            r = $urandom();
            wbase[j] = r[`MVU_BADDR-1:0];
            ibase[j] = r[2*`MVU_BADDR-1:`MVU_BADDR];
            obase[j] = r[3*`MVU_BADDR-1:2*`MVU_BADDR];
            wp  = JOBS[j].wp;
            ip  = JOBS[j].ip;
            wl  = wp * ip;                         // Cycles per word
            cd  = wl * JOBS[j].words;
            nxt = s + cd + 2 + JOBS[j].gap;        // Next start cycle
            for (c = 0; c < cd; c++) begin
                t    = s + 1 + c;
                wbit = c % wp;
                dbit = (c / wp) % ip;
                word = c / wl;
                exp_wreq[t] = '{addr: `MVU_BADDR'(wbase[j] + (c / wp) * wp + wbit), valid: 1'b1};
                exp_dreq[t] = '{addr: `MVU_BADDR'(ibase[j] + word * ip + dbit), valid: 1'b1};
                a.neg  = (JOBS[j].ds & (dbit == 0)) ^ (JOBS[j].ws & (wbit == 0));
                a.sh   = ((c % wl) != 0);
                a.acc  = 1'b1;
                a.load = ((c % wl) == wl - 1);
                exp_acc[t + PD] = a;
                if (a.load) begin
                    exp_out[t + PD + SL] = '{addr: `MVU_BADDR'(obase[j] + word), strobe: 1'b1};
                end
            end
            exp_done[s + cd + 1] = 1'b1;
            for (t = s + cd + 1; t <= nxt; t++) begin
                exp_irq[t] = 1'b1;                 // Held until the next start_q
            end
            limit += cd + JOBS[j].gap + 20;
            s = nxt;
        end
    endtask

    task automatic compare_cycle(input int t);
        if (uut.u_countdown.u_chk.fails != 0 || uut.u_acc_seq.u_chk.fails != 0) begin
            $display("A checker assertion failed by cycle %0d, time %0t", t, $time);
            $display("test failed");
            $fatal(1, "checker assertion");
        end
        check_req("wreq", wreq, exp_wreq[t]);
        check_req("dreq", dreq, exp_dreq[t]);
        check_acc(acc, exp_acc[t]);
        check_out(out, exp_out[t]);
        check_flag("done", done, exp_done[t]);
        check_flag("irq", irq, exp_irq[t]);
    endtask

    task automatic step_cycle(input logic strobe, input job_cfg_t c);
        @(posedge mvu_ext);
        #1;
        start = strobe;
        cfg   = c;
        @(negedge mvu_ext);
        compare_cycle(cyc);
        cyc++;
    endtask

    task automatic run_job(input int j);
        logic seen;
        step_cycle(1'b1, job_cfg(j));
        seen = 1'b0;
        while (!seen) begin
            step_cycle(1'b0, junk_cfg());           // cfg must not matter after start
            seen = done;
        end
        repeat (JOBS[j].gap) step_cycle(1'b0, junk_cfg());
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        cfg   = '0;
        cyc   = 0;
        void'($urandom(SEED));
        build_model();
        repeat (10) @(posedge mvu_ext);
        #1 rst_n = 1'b1;
        repeat (IDLE) step_cycle(1'b0, junk_cfg());
        for (int j = 0; j < NJOBS; j++) begin
            run_job(j);
        end
        if (uut.u_countdown.u_chk.fails != 0 || uut.u_acc_seq.u_chk.fails != 0) begin
            $display("A checker assertion failed near the end of the run");
            $display("test failed");
            $fatal(1, "checker assertion");
        end else begin
            $display("test passed");
            $finish;
        end
    end

    initial begin
        int unsigned ticks;
        ticks = 0;
        wait (rst_n === 1'b1);
        while (ticks < limit) begin
            @(posedge mvu_ext);
            ticks++;
        end
        $display("Timeout after %0d cycles, the run hung", ticks);
        $display("test failed");
        $fatal(1, "watchdog");
    end

endmodule
